// File: verilog/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    opLoad   = 7'b0000011,              // lw only
    opImm    = 7'b0010011,              // addi, slti, shifts by imm ...
    opAuipc  = 7'b0010111,
    opStore  = 7'b0100011,              // sw only
    opReg    = 7'b0110011,              // reg-reg arithmetic
    opLui    = 7'b0110111,
    opBranch = 7'b1100011,
    opJalr   = 7'b1100111,
    opJal    = 7'b1101111,
    opSystem = 7'b1110011               // ecall
  } rvOpcodeE;

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,                             // signed less than
    aluSltu,                            // unsigned less than
    aluSll,
    aluSrl,
    aluSra,
    aluPassB                            // lui, operand b straight out
  } aluOpE;

  // values follow branch funct3 so decode can cast directly
  typedef enum logic [2:0] {
    brEq  = 3'b000,
    brNe  = 3'b001,
    brLt  = 3'b100,
    brGe  = 3'b101,
    brLtu = 3'b110,
    brGeu = 3'b111
  } brCondE;

  localparam logic [31:0] haltCode = 32'd10;  // x17 value that makes ecall halt

endpackage

`default_nettype wire

// File: verilog/cpuBusPkg.sv
`default_nettype none

package cpuBusPkg;
  import rvIsaPkg::*;

  typedef enum logic [1:0] {
    wbAlu,                              // alu result
    wbMem,                              // data memory word
    wbLink                              // pc + 4 for jal / jalr
  } wbSelE;

  // control fields out of decode
  typedef struct packed {
    logic   isJal;
    logic   isJalr;
    logic   isBranch;
    brCondE brCond;
    logic   aluSrcImm;                  // operand b is the immediate
    logic   aluSrcPc;                   // operand a is the pc
    logic   memWrite;
    logic   regWrite;
    wbSelE  wbSel;
    logic   isEcall;
    aluOpE  aluOp;
  } ctrlT;

  typedef struct packed {
    ctrlT        ctrl;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;                   // sign extended by format
  } decT;

  typedef struct packed {
    logic [31:0] aluResult;
    logic [31:0] linkPc;                // pc + 4
    logic [31:0] nextPc;
  } exeT;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;
  } retireT;

endpackage

`default_nettype wire

// File: verilog/instFetch.sv
`timescale 1ns/100ps
`default_nettype none

module instFetch #(
  parameter int IMEM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          run,
  input  logic                          ecallHalt,
  input  logic [31:0]                   nextPc,
  input  logic                          loadEn,
  input  logic [$clog2(IMEM_WORDS)-1:0] loadAddr,
  input  logic [31:0]                   loadData,
  output logic [31:0]                   pc,
  output logic [31:0]                   inst,
  output logic                          isHalted
);

  localparam int IW = $clog2(IMEM_WORDS);
  localparam logic [31:0] NOP = 32'h0000_0013;  // addi x0, x0, 0

  logic [31:0] imem [IMEM_WORDS];       // no reset, program comes via load port
  logic        step;
  logic        pcInRange;

  assign step      = run && !isHalted;  // one instruction per edge
  assign pcInRange = {2'b00, pc[31:2]} < 32'(IMEM_WORDS);
  assign inst      = pcInRange ? imem[pc[IW+1:2]] : NOP;  // past the end reads as nop

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc       <= '0;
      isHalted <= 1'b0;
    end else if (step) begin
      pc <= nextPc;
      if (ecallHalt) begin
        isHalted <= 1'b1;               // sticky until reset
      end
    end
  end

  always_ff @(posedge clk) begin
    if (loadEn && (32'(loadAddr) < 32'(IMEM_WORDS))) begin
      imem[loadAddr] <= loadData;       // one word per clock
    end
  end

endmodule

`default_nettype wire

// File: verilog/instDecode.sv
`timescale 1ns/100ps
`default_nettype none

module instDecode import rvIsaPkg::*, cpuBusPkg::*; (
  input  logic [31:0] inst,
  input  logic [31:0] x17Data,
  output decT         dec,
  output logic        ecallHalt
);

  rvOpcodeE    opcode;
  logic [2:0]  funct3;
  ctrlT        ctrl;
  logic [31:0] imm;
  logic [31:0] immI, immS, immB, immU, immJ;

  assign opcode = rvOpcodeE'(inst[6:0]);
  assign funct3 = inst[14:12];

  // immediates by format, all sign extended from inst[31]
  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'b0};
  assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // funct3 to alu op, alt picks sub / sra
  function automatic aluOpE aluSel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  aluSel = alt ? aluSub : aluAdd;
      3'b001:  aluSel = aluSll;
      3'b010:  aluSel = aluSlt;
      3'b011:  aluSel = aluSltu;
      3'b100:  aluSel = aluXor;
      3'b101:  aluSel = alt ? aluSra : aluSrl;
      3'b110:  aluSel = aluOr;
      3'b111:  aluSel = aluAnd;
    endcase
  endfunction

  always_comb begin
    ctrl        = '0;                   // no-op unless an opcode matches
    ctrl.aluOp  = aluAdd;
    ctrl.brCond = brEq;
    ctrl.wbSel  = wbAlu;
    imm         = '0;
    case (opcode)
      opImm: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.aluOp     = aluSel(funct3, inst[30] && (funct3 == 3'b101));  // no subi
        imm            = immI;
      end
      opReg: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluSel(funct3, inst[30]);
      end
      opLui: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.aluOp     = aluPassB;
        imm            = immU;
      end
      opAuipc: begin
        ctrl.aluSrcPc  = 1'b1;          // pc + upper imm
        ctrl.aluSrcImm = 1'b1;
        ctrl.regWrite  = 1'b1;
        imm            = immU;
      end
      opLoad: begin
        if (funct3 == 3'b010) begin     // word only
          ctrl.aluSrcImm = 1'b1;
          ctrl.regWrite  = 1'b1;
          ctrl.wbSel     = wbMem;
          imm            = immI;
        end
      end
      opStore: begin
        if (funct3 == 3'b010) begin
          ctrl.aluSrcImm = 1'b1;
          ctrl.memWrite  = 1'b1;
          imm            = immS;
        end
      end
      opBranch: begin
        if (funct3[2:1] != 2'b01) begin  // 010 / 011 undefined
          ctrl.isBranch = 1'b1;
          ctrl.brCond   = brCondE'(funct3);
          imm           = immB;
        end
      end
      opJal: begin
        ctrl.isJal    = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.wbSel    = wbLink;
        imm           = immJ;
      end
      opJalr: begin
        ctrl.isJalr    = 1'b1;          // target from alu, rs1 + imm
        ctrl.aluSrcImm = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.wbSel     = wbLink;
        imm            = immI;
      end
      opSystem: begin
        ctrl.isEcall = (inst[31:7] == 25'd0);  // ebreak and csr fall to no-op
      end
      default: ;
    endcase
  end

  assign dec = '{ctrl: ctrl, rs1: inst[19:15], rs2: inst[24:20], rd: inst[11:7], imm: imm};
  assign ecallHalt = ctrl.isEcall && (x17Data == haltCode);  // exit syscall

endmodule

`default_nettype wire

// File: verilog/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
  input  logic        clk,
  input  logic        arstN,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic        wrEn,
  input  logic [4:0]  wrAddr,
  input  logic [31:0] wrData,
  output logic [31:0] rs1Data,
  output logic [31:0] rs2Data,
  output logic [31:0] x17Data
);

  logic [31:0] regs [32];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != 5'd0)) begin  // x0 stays zero
      regs[wrAddr] <= wrData;
    end
  end

  // async read ports, same-cycle write not forwarded
  assign rs1Data = regs[rs1];
  assign rs2Data = regs[rs2];
  assign x17Data = regs[17];            // a7, syscall number

endmodule

`default_nettype wire

// File: verilog/aluExecute.sv
`timescale 1ns/100ps
`default_nettype none

module aluExecute import rvIsaPkg::*, cpuBusPkg::*; (
  input  decT         dec,
  input  logic [31:0] pc,
  input  logic [31:0] rs1Data,
  input  logic [31:0] rs2Data,
  output exeT         exe
);

  logic [31:0] opA, opB;
  logic [31:0] aluRes;
  logic [31:0] pcPlus4, pcTarget;
  logic [4:0]  shamt;
  logic        brTaken;

  assign opA   = dec.ctrl.aluSrcPc ? pc : rs1Data;
  assign opB   = dec.ctrl.aluSrcImm ? dec.imm : rs2Data;
  assign shamt = opB[4:0];              // low 5 bits only

  always_comb begin
    case (dec.ctrl.aluOp)
      aluAdd:   aluRes = opA + opB;
      aluSub:   aluRes = opA - opB;
      aluAnd:   aluRes = opA & opB;
      aluOr:    aluRes = opA | opB;
      aluXor:   aluRes = opA ^ opB;
      aluSlt:   aluRes = {31'b0, $signed(opA) < $signed(opB)};
      aluSltu:  aluRes = {31'b0, opA < opB};
      aluSll:   aluRes = opA << shamt;
      aluSrl:   aluRes = opA >> shamt;
      aluSra:   aluRes = 32'($signed(opA) >>> shamt);  // sign fill
      aluPassB: aluRes = opB;
      default:  aluRes = opA + opB;
    endcase
  end

  // compare on register values, alu is busy with nothing else here
  always_comb begin
    case (dec.ctrl.brCond)
      brEq:    brTaken = (rs1Data == rs2Data);
      brNe:    brTaken = (rs1Data != rs2Data);
      brLt:    brTaken = ($signed(rs1Data) < $signed(rs2Data));
      brGe:    brTaken = ($signed(rs1Data) >= $signed(rs2Data));
      brLtu:   brTaken = (rs1Data < rs2Data);
      brGeu:   brTaken = (rs1Data >= rs2Data);
      default: brTaken = 1'b0;
    endcase
  end

  assign pcPlus4  = pc + 32'd4;
  assign pcTarget = pc + dec.imm;       // jal and branch target

  assign exe.aluResult = aluRes;
  assign exe.linkPc    = pcPlus4;
  assign exe.nextPc    = dec.ctrl.isJalr ? {aluRes[31:1], 1'b0} :
                         (dec.ctrl.isJal || (dec.ctrl.isBranch && brTaken)) ? pcTarget :
                         pcPlus4;

endmodule

`default_nettype wire

// File: verilog/resultWrite.sv
`timescale 1ns/100ps
`default_nettype none

module resultWrite import cpuBusPkg::*; #(
  parameter int DMEM_WORDS = 256
) (
  input  logic        clk,
  input  logic        run,
  input  logic        isHalted,
  input  decT         dec,
  input  exeT         exe,
  input  logic [31:0] rs2Data,
  output logic        wrEn,
  output logic [4:0]  wrAddr,
  output logic [31:0] wrData,
  output retireT      retire
);

  localparam int DW = $clog2(DMEM_WORDS);

  logic [31:0]   dmem [DMEM_WORDS];     // word memory, contents undefined at start
  logic [DW-1:0] memIdx;
  logic          memHit;
  logic [31:0]   memRd;
  logic          active;

  assign active = run && !isHalted;
  assign memIdx = exe.aluResult[DW+1:2];  // byte address to word index
  assign memHit = {2'b00, exe.aluResult[31:2]} < 32'(DMEM_WORDS);
  assign memRd  = memHit ? dmem[memIdx] : '0;  // async read, out of range gives 0

  always_ff @(posedge clk) begin
    if (active && dec.ctrl.memWrite && memHit) begin
      dmem[memIdx] <= rs2Data;          // sw, same edge as pc update
    end
  end

  always_comb begin
    case (dec.ctrl.wbSel)
      wbMem:   wrData = memRd;
      wbLink:  wrData = exe.linkPc;
      default: wrData = exe.aluResult;
    endcase
  end

  assign wrAddr = dec.rd;
  assign wrEn   = active && dec.ctrl.regWrite && (dec.rd != 5'd0);  // x0 never retires

  // trace shows the write about to commit
  assign retire = '{valid: wrEn, rd: wrAddr, data: wrData};

endmodule

`default_nettype wire

// File: verilog/cpuTop.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTop import cpuBusPkg::*; #(
  parameter int IMEM_WORDS = 256,
  parameter int DMEM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          run,
  input  logic                          loadEn,
  input  logic [$clog2(IMEM_WORDS)-1:0] loadAddr,
  input  logic [31:0]                   loadData,
  output logic                          isHalted,
  output retireT                        retire
);

  logic [31:0] pc, inst;
  logic [31:0] rs1Data, rs2Data, x17Data;
  logic [31:0] wrData;
  logic [4:0]  wrAddr;
  logic        wrEn;
  logic        ecallHalt;
  decT         dec;
  exeT         exe;

  instFetch #(.IMEM_WORDS(IMEM_WORDS)) i_instFetch (
    .clk(clk), .arstN(arstN), .run(run),
    .ecallHalt(ecallHalt),              // from decode, latched here
    .nextPc(exe.nextPc),
    .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
    .pc(pc), .inst(inst), .isHalted(isHalted)
  );

  instDecode i_instDecode (
    .inst(inst), .x17Data(x17Data),
    .dec(dec), .ecallHalt(ecallHalt)
  );

  regFile i_regFile (
    .clk(clk), .arstN(arstN),
    .rs1(dec.rs1), .rs2(dec.rs2),
    .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
    .rs1Data(rs1Data), .rs2Data(rs2Data), .x17Data(x17Data)
  );

  aluExecute i_aluExecute (
    .dec(dec), .pc(pc),
    .rs1Data(rs1Data), .rs2Data(rs2Data),
    .exe(exe)
  );

  resultWrite #(.DMEM_WORDS(DMEM_WORDS)) i_resultWrite (
    .clk(clk), .run(run), .isHalted(isHalted),
    .dec(dec), .exe(exe), .rs2Data(rs2Data),  // rs2 is store data
    .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
    .retire(retire)
  );

endmodule

`default_nettype wire

// File: test/cpuTb.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTb import cpuBusPkg::*; ();

  localparam int IMEM_WORDS = 256;
  localparam int DMEM_WORDS = 256;
  localparam int AW         = $clog2(IMEM_WORDS);
  localparam int DRAIN      = 8;         // idle cycles after halt, catches late retires

  logic          clk;
  logic          arstN;
  logic          run;
  logic          loadEn;
  logic [AW-1:0] loadAddr;
  logic [31:0]   loadData;
  logic          isHalted;
  retireT        retire;

  logic [31:0] progWords [$];            // P lines
  logic [4:0]  expRd [$];                // W lines, rd column
  logic [31:0] expData [$];              // W lines, data column
  int          wIdx;                     // next expected write-back
  int          valueErrors;
  int          extraErrors;
  int          otherErrors;
  int          cycles;
  int          limit;

  cpuTop #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) i_cpuTop (
    .clk(clk), .arstN(arstN), .run(run),
    .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
    .isHalted(isHalted), .retire(retire)
  );

  always #10 clk = ~clk;                 // 20 ns period

  // tag in column 0, hex fields after it, anything else is a comment
  task automatic readVectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    fd = $fopen("test/cpuVectors.txt", "r");
    if (fd == 0) begin
      $display("could not open test/cpuVectors.txt for reading");
      otherErrors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1) begin
        if (line.getc(0) == "P") begin
          if ($sscanf(line.substr(1, line.len() - 1), "%h", a) == 1) begin
            progWords.push_back(a);
          end
        end else if (line.getc(0) == "W") begin
          if ($sscanf(line.substr(1, line.len() - 1), "%h %h", a, b) == 2) begin
            expRd.push_back(a[4:0]);
            expData.push_back(b);
          end
        end
      end
    end
    $fclose(fd);
  endtask

  // retire is settled from the previous falling edge, sample before state moves
  always @(posedge clk) begin
    if (arstN && retire.valid) begin
      assert (wIdx < expRd.size())
        else begin
          $display("unexpected retire after the last expected write-back: x%0d = 0x%08h",
                   retire.rd, retire.data);
          extraErrors++;
        end
      if (wIdx < expRd.size()) begin
        assert (retire.rd == expRd[wIdx])
          else begin
            $display("Fail retire %0d rd: expected x%0d actual x%0d",
                     wIdx, expRd[wIdx], retire.rd);
            valueErrors++;
          end
        assert (retire.data == expData[wIdx])
          else begin
            $display("Fail retire %0d data: expected 0x%08h actual 0x%08h",
                     wIdx, expData[wIdx], retire.data);
            valueErrors++;
          end
        wIdx++;
      end
    end
  end

  initial begin
    clk         = 1'b0;
    arstN       = 1'b0;
    run         = 1'b0;
    loadEn      = 1'b0;
    loadAddr    = '0;
    loadData    = '0;
    wIdx        = 0;
    valueErrors = 0;
    extraErrors = 0;
    otherErrors = 0;
    readVectors();
    limit = 2 * progWords.size() + 50;   // no backward branches in the program

    repeat (4) @(negedge clk);
    arstN = 1'b1;
    assert (!isHalted && !retire.valid)
      else begin
        $display("core not idle after reset: isHalted %b, retire.valid %b",
                 isHalted, retire.valid);
        otherErrors++;
      end

    foreach (progWords[i]) begin         // one word per clock through the load port
      loadEn   = 1'b1;
      loadAddr = AW'(i);
      loadData = progWords[i];
      @(negedge clk);
    end
    loadEn = 1'b0;
    run    = 1'b1;

    cycles = 0;
    while (!isHalted && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    assert (isHalted)
      else begin
        $display("timeout: core did not halt within %0d cycles", limit);
        otherErrors++;
      end

    repeat (DRAIN) @(negedge clk);       // halted core must stay silent
    assert (wIdx == expRd.size())
      else begin
        $display("%0d expected write-backs never retired", expRd.size() - wIdx);
        otherErrors++;
      end

    $display("errors: %0d wrong value, %0d extra retire, %0d other",
             valueErrors, extraErrors, otherErrors);
    if (valueErrors + extraErrors + otherErrors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/cpuVectors.txt
# P <word>       program word, loaded at consecutive word addresses from 0
# W <rd> <data>  expected register write-back, in retire order
P 00500093  # 00 addi x1, x0, 5
P FFD00113  # 04 addi x2, x0, -3
P 002081B3  # 08 add  x3, x1, x2
P 40208233  # 0C sub  x4, x1, x2
P 0020F2B3  # 10 and  x5, x1, x2
P 0020E333  # 14 or   x6, x1, x2
P 0020C3B3  # 18 xor  x7, x1, x2
P 00112433  # 1C slt  x8, x2, x1
P 001134B3  # 20 sltu x9, x2, x1
P 00109533  # 24 sll  x10, x1, x1
P 40115593  # 28 srai x11, x2, 1
P 01C15613  # 2C srli x12, x2, 28
P 123456B7  # 30 lui  x13, 0x12345
P 00001717  # 34 auipc x14, 1
P 00D02423  # 38 sw   x13, 8(x0)
P 00802783  # 3C lw   x15, 8(x0)
P 00708013  # 40 addi x0, x1, 7   no retire
P 00904813  # 44 xori x16, x0, 9  x0 reads 0
P 00208463  # 48 beq  x1, x2, +8  not taken
P 00108463  # 4C beq  x1, x1, +8  taken
P FFF00A93  # 50 addi x21, x0, -1 skipped
P 00109463  # 54 bne  x1, x1, +8  not taken
P 00209463  # 58 bne  x1, x2, +8  taken
P FFF00A93  # 5C skipped
P 0020C463  # 60 blt  x1, x2, +8  not taken
P 00114463  # 64 blt  x2, x1, +8  taken
P FFF00A93  # 68 skipped
P 00115463  # 6C bge  x2, x1, +8  not taken
P 0020D463  # 70 bge  x1, x2, +8  taken
P FFF00A93  # 74 skipped
P 00116463  # 78 bltu x2, x1, +8  not taken
P 0020E463  # 7C bltu x1, x2, +8  taken
P FFF00A93  # 80 skipped
P 0020F463  # 84 bgeu x1, x2, +8  not taken
P 00117463  # 88 bgeu x2, x1, +8  taken
P FFF00A93  # 8C skipped
P 00800B6F  # 90 jal  x22, +8
P FFF00A93  # 94 skipped
P 00000B97  # 98 auipc x23, 0
P 00DB8C67  # 9C jalr x24, 13(x23)  target A4, bit 0 cleared
P FFF00A93  # A0 skipped
P 00000073  # A4 ecall  x17 = 0, keeps running
P 00A00893  # A8 addi x17, x0, 10
P 00000073  # AC ecall  halts
P FFF00A93  # B0 never runs
W 01 00000005
W 02 FFFFFFFD
W 03 00000002
W 04 00000008
W 05 00000005
W 06 FFFFFFFD
W 07 FFFFFFF8
W 08 00000001
W 09 00000000
W 0A 000000A0
W 0B FFFFFFFE
W 0C 0000000F
W 0D 12345000
W 0E 00001034
W 0F 12345000
W 10 00000009
W 16 00000094
W 17 00000098
W 18 000000A0
W 11 0000000A

// File: tb.f
verilog/rvIsaPkg.sv
verilog/cpuBusPkg.sv
verilog/instFetch.sv
verilog/instDecode.sv
verilog/regFile.sv
verilog/aluExecute.sv
verilog/resultWrite.sv
verilog/cpuTop.sv
test/cpuTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# build and run the cpuTb simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f --top-module cpuTb -o cpuSim

./obj_dir/cpuSim | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
else
  exit 1
fi
